// File: common/dc_fifo_defines.svh
/*
 * Sizing macros for the dual-clock FIFO
 * Data and address widths, synchronizer depth, control-port map
 */
`ifndef DC_FIFO_DEFINES_SVH
`define DC_FIFO_DEFINES_SVH

// --------------------
// Stream and memory
// Payload word width
`define DCF_DATA_WIDTH   16
// 16 entries
`define DCF_ADDR_WIDTH   4
// Flops per pointer synchronizer
`define DCF_SYNC_STAGES  2

// --------------------
// Control port
`define DCF_THRESH_WIDTH 24
`define DCF_CSR_WIDTH    32
// Word addresses, one address bit
`define DCF_CSR_FILL     1'b0
`define DCF_CSR_THRESH   1'b1

`endif

// File: common/dc_fifo_stream_pkg.sv
/*
 * Stream types: data word, packet beat and streamed status flag
 */
`include "dc_fifo_defines.svh"

package dc_fifo_stream_pkg;

    // One payload word
    typedef logic [`DCF_DATA_WIDTH-1:0] data_t;

    // Beat as stored in memory and carried on both streams
    typedef struct packed {
        logic  sop;
        logic  eop;
        data_t data;
    } beat_t;

    // Streamed almost-full / almost-empty status
    typedef struct packed {
        logic valid;
        logic flag;
    } status_t;

endpackage

// File: common/dc_fifo_ptr_pkg.sv
/*
 * Pointer, level and control-port types
 * Gray encode and decode for the pointer crossings
 */
`include "dc_fifo_defines.svh"

package dc_fifo_ptr_pkg;

    typedef logic [`DCF_ADDR_WIDTH-1:0]   addr_t;
    // Address plus wrap bit, binary or Gray
    typedef logic [`DCF_ADDR_WIDTH:0]     ptr_t;
    // Up to depth plus the output register
    typedef logic [`DCF_ADDR_WIDTH:0]     level_t;
    typedef logic [`DCF_THRESH_WIDTH-1:0] thresh_t;
    typedef logic [`DCF_CSR_WIDTH-1:0]    csr_data_t;

    // Control-port request, one per side
    typedef struct packed {
        logic      address;
        logic      read;
        logic      write;
        csr_data_t writedata;
    } csr_req_t;

    // Adjacent codes differ in one bit only
    function automatic ptr_t bin_to_gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // Each binary bit is the XOR of all Gray bits at and above it
    function automatic ptr_t gray_to_bin(input ptr_t gray);
        ptr_t bin;
        bin[`DCF_ADDR_WIDTH] = gray[`DCF_ADDR_WIDTH];
        for (int i = `DCF_ADDR_WIDTH - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// File: ptr_ctrl/gray_sync.sv
/*
 * Pointer synchronizer chain with Gray-to-binary decode
 */
`timescale 1ns/1ps
`include "dc_fifo_defines.svh"

module gray_sync #(
    parameter int STAGES = `DCF_SYNC_STAGES
) (
    input  logic                  dst_clk,
    input  logic                  dst_reset_n,
    input  dc_fifo_ptr_pkg::ptr_t gray_in,
    output dc_fifo_ptr_pkg::ptr_t bin_out
);
    import dc_fifo_ptr_pkg::*;

    // First stage may go metastable, later stages settle it
    ptr_t sync_q [STAGES];

    always_ff @(posedge dst_clk or negedge dst_reset_n) begin
        if (!dst_reset_n) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= gray_in;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Decode after the last stage only
    assign bin_out = gray_to_bin(sync_q[STAGES-1]);

endmodule

// File: ptr_ctrl/wr_ptr_ctrl.sv
/*
 * Write pointer, its Gray copy, full flag and write-side fill level
 */
`timescale 1ns/1ps
`include "dc_fifo_defines.svh"

module wr_ptr_ctrl (
    input  logic                   in_clk,
    input  logic                   in_reset_n,
    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  dc_fifo_ptr_pkg::ptr_t  rd_ptr_bin,
    output dc_fifo_ptr_pkg::addr_t wr_addr,
    output logic                   wr_en,
    output dc_fifo_ptr_pkg::ptr_t  wr_ptr_gray,
    output dc_fifo_ptr_pkg::level_t wr_level
);
    import dc_fifo_ptr_pkg::*;

    ptr_t wr_ptr;
    ptr_t wr_ptr_next;
    logic full;

    // Beat accepted this cycle
    assign wr_ready    = !full;
    assign wr_en       = wr_valid && wr_ready;
    assign wr_ptr_next = wr_ptr + ptr_t'(wr_en);
    assign wr_addr     = addr_t'(wr_ptr);

    // --------------------
    // Pointer, crossing copy and status
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
            full        <= 1'b0;
            wr_level    <= '0;
        end else begin
            wr_ptr      <= wr_ptr_next;
            // Gray of the settled pointer, the word is already in memory
            wr_ptr_gray <= bin_to_gray(wr_ptr);
            // Same address, opposite wrap bit
            full        <= (wr_ptr_next[`DCF_ADDR_WIDTH-1:0] ==
                            rd_ptr_bin[`DCF_ADDR_WIDTH-1:0]) &&
                           (wr_ptr_next[`DCF_ADDR_WIDTH] != rd_ptr_bin[`DCF_ADDR_WIDTH]);
            // Memory only, pessimistic through the synchronizer
            wr_level    <= wr_ptr_next - rd_ptr_bin;
        end
    end

endmodule

// File: ptr_ctrl/rd_ptr_ctrl.sv
/*
 * Read pointer, its Gray copy, empty flag and memory fill level
 */
`timescale 1ns/1ps

module rd_ptr_ctrl (
    input  logic                    rd_clk,
    input  logic                    rd_reset_n,
    input  logic                    take,
    input  dc_fifo_ptr_pkg::ptr_t   wr_ptr_bin,
    output dc_fifo_ptr_pkg::addr_t  rd_addr,
    output dc_fifo_ptr_pkg::ptr_t   rd_ptr_gray,
    output logic                    avail,
    output dc_fifo_ptr_pkg::level_t mem_level
);
    import dc_fifo_ptr_pkg::*;

    ptr_t rd_ptr;
    ptr_t rd_ptr_next;
    logic empty;
    logic pop;

    // Pop when a word is there and the output register can take it
    assign avail       = !empty;
    assign pop         = avail && take;
    assign rd_ptr_next = rd_ptr + ptr_t'(pop);

    // Memory reads ahead at the next pointer
    assign rd_addr = addr_t'(rd_ptr_next);

    // --------------------
    // Pointer, crossing copy and status
    always_ff @(posedge rd_clk or negedge rd_reset_n) begin
        if (!rd_reset_n) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            empty       <= 1'b1;
            mem_level   <= '0;
        end else begin
            rd_ptr      <= rd_ptr_next;
            rd_ptr_gray <= bin_to_gray(rd_ptr);
            // Empty when both pointers match, wrap bit included
            empty       <= (rd_ptr_next == wr_ptr_bin);
            // Words left in memory, output register not counted
            mem_level   <= wr_ptr_bin - rd_ptr_next;
        end
    end

endmodule

// File: source/dc_fifo_mem.sv
/*
 * Dual-clock beat memory with registered read
 */
`timescale 1ns/1ps
`include "dc_fifo_defines.svh"

module dc_fifo_mem (
    input  logic                      in_clk,
    input  logic                      rd_clk,
    input  logic                      wr_en,
    input  dc_fifo_ptr_pkg::addr_t    wr_addr,
    input  dc_fifo_stream_pkg::beat_t wr_beat,
    input  dc_fifo_ptr_pkg::addr_t    rd_addr,
    output dc_fifo_stream_pkg::beat_t rd_beat
);
    import dc_fifo_stream_pkg::*;

    // One entry per address
    beat_t mem [1 << `DCF_ADDR_WIDTH];

    // Write port on the write clock
    always_ff @(posedge in_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // Read port on the read clock
    // Address comes from the next read pointer, so data lines up with empty
    always_ff @(posedge rd_clk) begin
        rd_beat <= mem[rd_addr];
    end

endmodule

// File: source/dc_fifo_out_stage.sv
/*
 * Registered output stage and read-side fill level
 */
`timescale 1ns/1ps

module dc_fifo_out_stage (
    input  logic                      rd_clk,
    input  logic                      rd_reset_n,
    input  logic                      avail,
    input  dc_fifo_stream_pkg::beat_t mem_beat,
    input  dc_fifo_ptr_pkg::level_t   mem_level,
    input  logic                      rd_ready,
    output logic                      take,
    output dc_fifo_stream_pkg::beat_t rd_beat,
    output logic                      rd_valid,
    output dc_fifo_ptr_pkg::level_t   out_level
);
    import dc_fifo_ptr_pkg::*;

    // Register free, or being drained this cycle
    assign take = !rd_valid || rd_ready;

    // --------------------
    // Valid bit
    always_ff @(posedge rd_clk or negedge rd_reset_n) begin
        if (!rd_reset_n) begin
            rd_valid <= 1'b0;
        end else if (take) begin
            rd_valid <= avail;
        end
    end

    // Payload, held steady while stalled
    always_ff @(posedge rd_clk) begin
        if (take) begin
            rd_beat <= mem_beat;
        end
    end

    // Held beat counts too, so a full FIFO reads depth plus one
    assign out_level = mem_level + level_t'(rd_valid);

endmodule

// File: source/level_csr.sv
/*
 * Two-word control port with threshold register
 * Streamed almost-full or almost-empty flag
 */
`timescale 1ns/1ps
`include "dc_fifo_defines.svh"

module level_csr #(
    // 1 compares level >= threshold, 0 compares level <= threshold
    parameter bit FULL_SIDE = 1'b1
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  dc_fifo_ptr_pkg::level_t     level,
    input  dc_fifo_ptr_pkg::csr_req_t   csr,
    output dc_fifo_ptr_pkg::csr_data_t  csr_readdata,
    output dc_fifo_stream_pkg::status_t almost
);
    import dc_fifo_ptr_pkg::*;

    thresh_t threshold;
    thresh_t level_ext;
    logic    hit;

    // Level widened to the threshold field
    assign level_ext = thresh_t'(level);

    // Comparison direction fixed per side
    assign hit = FULL_SIDE ? (level_ext >= threshold) : (level_ext <= threshold);

    // --------------------
    // Register access
    // Word 0 level (read only), word 1 threshold
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            threshold    <= '0;
            csr_readdata <= '0;
        end else begin
            if (csr.write) begin
                // Write wins over a read in the same cycle
                if (csr.address == `DCF_CSR_THRESH) begin
                    threshold <= csr.writedata[`DCF_THRESH_WIDTH-1:0];
                end
            end else if (csr.read) begin
                // Upper byte reads as zero
                if (csr.address == `DCF_CSR_FILL) begin
                    csr_readdata <= csr_data_t'(level_ext);
                end else begin
                    csr_readdata <= csr_data_t'(threshold);
                end
            end
        end
    end

    // --------------------
    // Streamed status
    // Valid from the first cycle out of reset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            almost.valid <= 1'b0;
            almost.flag  <= 1'b0;
        end else begin
            almost.valid <= 1'b1;
            almost.flag  <= hit;
        end
    end

endmodule

// File: source/dc_fifo_top.sv
/*
 * Dual-clock streaming FIFO with fill levels and streamed status
 * Memory, pointer controllers, crossings, output stage, control ports
 */
`timescale 1ns/1ps

module dc_fifo_top (
    input  logic                        in_clk,
    input  logic                        in_reset_n,
    input  logic                        rd_clk,
    input  logic                        rd_reset_n,
    input  dc_fifo_stream_pkg::beat_t   wr_beat,
    input  logic                        wr_valid,
    output logic                        wr_ready,
    output dc_fifo_stream_pkg::beat_t   rd_beat,
    output logic                        rd_valid,
    input  logic                        rd_ready,
    input  dc_fifo_ptr_pkg::csr_req_t   wr_csr,
    input  dc_fifo_ptr_pkg::csr_req_t   rd_csr,
    output dc_fifo_ptr_pkg::csr_data_t  wr_csr_readdata,
    output dc_fifo_ptr_pkg::csr_data_t  rd_csr_readdata,
    output dc_fifo_stream_pkg::status_t almost_full,
    output dc_fifo_stream_pkg::status_t almost_empty
);
    import dc_fifo_stream_pkg::*;
    import dc_fifo_ptr_pkg::*;

    // Write domain
    addr_t  wr_addr;
    logic   wr_en;
    ptr_t   wr_ptr_gray;
    ptr_t   rd_ptr_bin;
    level_t wr_level;

    // Read domain
    addr_t  rd_addr;
    ptr_t   rd_ptr_gray;
    ptr_t   wr_ptr_bin;
    beat_t  mem_beat;
    logic   avail;
    logic   take;
    level_t mem_level;
    level_t out_level;

    // --------------------
    // Storage and pointers
    dc_fifo_mem u_mem (
        .in_clk  (in_clk),
        .rd_clk  (rd_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_beat (wr_beat),
        .rd_addr (rd_addr),
        .rd_beat (mem_beat)
    );

    wr_ptr_ctrl u_wr_ctrl (
        .in_clk      (in_clk),
        .in_reset_n  (in_reset_n),
        .wr_valid    (wr_valid),
        .wr_ready    (wr_ready),
        .rd_ptr_bin  (rd_ptr_bin),
        .wr_addr     (wr_addr),
        .wr_en       (wr_en),
        .wr_ptr_gray (wr_ptr_gray),
        .wr_level    (wr_level)
    );

    rd_ptr_ctrl u_rd_ctrl (
        .rd_clk      (rd_clk),
        .rd_reset_n  (rd_reset_n),
        .take        (take),
        .wr_ptr_bin  (wr_ptr_bin),
        .rd_addr     (rd_addr),
        .rd_ptr_gray (rd_ptr_gray),
        .avail       (avail),
        .mem_level   (mem_level)
    );

    // --------------------
    // Pointer crossings
    // Write pointer into the read clock
    gray_sync u_wr_sync (
        .dst_clk     (rd_clk),
        .dst_reset_n (rd_reset_n),
        .gray_in     (wr_ptr_gray),
        .bin_out     (wr_ptr_bin)
    );

    // Read pointer into the write clock
    gray_sync u_rd_sync (
        .dst_clk     (in_clk),
        .dst_reset_n (in_reset_n),
        .gray_in     (rd_ptr_gray),
        .bin_out     (rd_ptr_bin)
    );

    // --------------------
    // Output register
    dc_fifo_out_stage u_out (
        .rd_clk     (rd_clk),
        .rd_reset_n (rd_reset_n),
        .avail      (avail),
        .mem_beat   (mem_beat),
        .mem_level  (mem_level),
        .rd_ready   (rd_ready),
        .take       (take),
        .rd_beat    (rd_beat),
        .rd_valid   (rd_valid),
        .out_level  (out_level)
    );

    // --------------------
    // Control ports and streamed status
    // Almost full when write level reaches the threshold
    level_csr #(.FULL_SIDE(1'b1)) u_wr_csr (
        .clk          (in_clk),
        .reset_n      (in_reset_n),
        .level        (wr_level),
        .csr          (wr_csr),
        .csr_readdata (wr_csr_readdata),
        .almost       (almost_full)
    );

    // Almost empty when read level drops to the threshold
    level_csr #(.FULL_SIDE(1'b0)) u_rd_csr (
        .clk          (rd_clk),
        .reset_n      (rd_reset_n),
        .level        (out_level),
        .csr          (rd_csr),
        .csr_readdata (rd_csr_readdata),
        .almost       (almost_empty)
    );

endmodule

// File: dv/tb_dc_fifo.sv
/*
 * Testbench for the dual-clock FIFO
 * Table of stream tests, queue model, control-port and status checks
 */
`timescale 1ns/1ps
`include "dc_fifo_defines.svh"

module tb_dc_fifo;
    import dc_fifo_stream_pkg::*;
    import dc_fifo_ptr_pkg::*;

    localparam int NUM_ROWS = 3;
    localparam int DEPTH    = 1 << `DCF_ADDR_WIDTH;
    // Cycles of settling before a level or flag is read
    localparam int SETTLE   = 20;

    // One row of the test table
    typedef struct packed {
        int        n_beats;
        data_t     base;
        int        pkt_len;
        bit        gaps;
        bit        stalls;
        // rd_ready low until the FIFO fills
        bit        hold;
        csr_data_t wr_thresh;
        csr_data_t rd_thresh;
        csr_data_t exp_wr_thresh;
        csr_data_t exp_rd_thresh;
        csr_data_t exp_accept;
        csr_data_t full_wr_level;
        csr_data_t full_rd_level;
        status_t   full_af;
        status_t   full_ae;
        status_t   drain_af;
        status_t   drain_ae;
    } test_row_t;

    logic      in_clk;
    logic      in_reset_n;
    logic      rd_clk;
    logic      rd_reset_n;
    beat_t     wr_beat;
    logic      wr_valid;
    logic      wr_ready;
    beat_t     rd_beat;
    logic      rd_valid;
    logic      rd_ready;
    csr_req_t  wr_csr;
    csr_req_t  rd_csr;
    csr_data_t wr_csr_readdata;
    csr_data_t rd_csr_readdata;
    status_t   almost_full;
    status_t   almost_empty;

    test_row_t test_table [NUM_ROWS];
    string     row_name [NUM_ROWS];
    test_row_t row;
    string     cur_name;
    // Reference model of the beats in acceptance order
    beat_t     model_q [$];
    int        accepted;
    int        stall_run;
    bit        hold_rd;
    int        test_errors;
    int        total_errors;
    int        tests_run;
    int        tests_failed;
    int        cycles = 0;
    int        cycle_limit = 0;

    dc_fifo_top dut0 (
        .in_clk          (in_clk),
        .in_reset_n      (in_reset_n),
        .rd_clk          (rd_clk),
        .rd_reset_n      (rd_reset_n),
        .wr_beat         (wr_beat),
        .wr_valid        (wr_valid),
        .wr_ready        (wr_ready),
        .rd_beat         (rd_beat),
        .rd_valid        (rd_valid),
        .rd_ready        (rd_ready),
        .wr_csr          (wr_csr),
        .rd_csr          (rd_csr),
        .wr_csr_readdata (wr_csr_readdata),
        .rd_csr_readdata (rd_csr_readdata),
        .almost_full     (almost_full),
        .almost_empty    (almost_empty)
    );

    // --------------------
    // Clocks and run limit
    initial begin
        in_clk = 1'b0;
        forever #2 in_clk = ~in_clk;
    end

    // Read clock of 6 ns whose edges never meet a write edge
    initial begin
        rd_clk = 1'b0;
        forever #3 rd_clk = ~rd_clk;
    end

    always @(posedge in_clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run stopped after %0d write-clock cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // --------------------
    // Checks and per-test bookkeeping
    task automatic check_beat(input string what, input beat_t exp, input beat_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_word(input string what, input csr_data_t exp, input csr_data_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string what, input status_t exp, input status_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    // Single handshake bits
    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %s: %s", cur_name, msg);
        test_errors++;
    endtask

    task automatic start_test(input string name);
        cur_name    = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: passed", cur_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_name, test_errors);
        end
    endtask

    // --------------------
    // Stimulus helpers
    // Beat i of the current row in packets of pkt_len beats
    function automatic beat_t make_beat(input int i);
        beat_t b;
        b.data = row.base + data_t'(i * 7);
        b.sop  = (i % row.pkt_len) == 0;
        b.eop  = ((i % row.pkt_len) == row.pkt_len - 1) || (i == row.n_beats - 1);
        return b;
    endfunction

    // Drive point just after the edge of one side
    task automatic side_edge(input bit rd_side);
        if (rd_side) begin
            @(posedge rd_clk);
        end else begin
            @(posedge in_clk);
        end
        #0.5;
    endtask

    // One access on a control port with read data one cycle later
    task automatic csr_access(input bit rd_side, input logic addr, input bit wr,
                              input csr_data_t wdata, output csr_data_t rdata);
        csr_req_t req;
        req.address   = addr;
        req.read      = !wr;
        req.write     = wr;
        req.writedata = wdata;
        side_edge(rd_side);
        if (rd_side) begin
            rd_csr = req;
        end else begin
            wr_csr = req;
        end
        side_edge(rd_side);
        if (rd_side) begin
            rd_csr = '0;
            rdata  = rd_csr_readdata;
        end else begin
            wr_csr = '0;
            rdata  = wr_csr_readdata;
        end
    endtask

    // Write stream with optional random gaps
    task automatic send_beats();
        int i;
        bit ready_seen;
        i = 0;
        side_edge(1'b0);
        while (i < row.n_beats) begin
            wr_beat    = make_beat(i);
            wr_valid   = !(row.gaps && $urandom_range(0, 3) == 0);
            // wr_ready is registered and holds through the coming edge
            ready_seen = wr_ready;
            side_edge(1'b0);
            if (wr_valid && ready_seen) begin
                model_q.push_back(wr_beat);
                accepted++;
                stall_run = 0;
                i++;
            end else if (wr_valid) begin
                stall_run++;
            end
        end
        wr_valid = 1'b0;
    endtask

    // Read stream that compares each beat as it leaves
    task automatic receive_beats();
        int    got;
        logic  valid_seen;
        beat_t beat_seen;
        got = 0;
        side_edge(1'b1);
        valid_seen = rd_valid;
        beat_seen  = rd_beat;
        while (got < row.n_beats) begin
            if (hold_rd) begin
                rd_ready = 1'b0;
            end else if (row.stalls) begin
                rd_ready = ($urandom_range(0, 2) != 0);
            end else begin
                rd_ready = 1'b1;
            end
            side_edge(1'b1);
            if (rd_ready && valid_seen) begin
                if (model_q.size() == 0) begin
                    report_error("a beat came out that was never accepted");
                end else begin
                    check_beat($sformatf("beat %0d", got), model_q.pop_front(), beat_seen);
                end
                got++;
            end
            valid_seen = rd_valid;
            beat_seen  = rd_beat;
        end
        rd_ready = 1'b0;
    endtask

    // Checks the full state with the reader stalled and then lets the reader go
    task automatic check_full_state();
        csr_data_t rdata;
        wait (stall_run >= SETTLE);
        side_edge(1'b0);
        check_word("accepted beats", row.exp_accept, accepted);
        check_bit("wr_ready when full", 1'b0, wr_ready);
        check_bit("rd_valid while stalled", 1'b1, rd_valid);
        check_beat("held beat", make_beat(0), rd_beat);
        csr_access(1'b0, `DCF_CSR_FILL, 1'b0, '0, rdata);
        check_word("write level when full", row.full_wr_level, rdata);
        check_flag("almost_full when full", row.full_af, almost_full);
        csr_access(1'b1, `DCF_CSR_FILL, 1'b0, '0, rdata);
        check_word("read level when full", row.full_rd_level, rdata);
        check_flag("almost_empty when full", row.full_ae, almost_empty);
        // Nothing taken yet and the first beat still held
        side_edge(1'b0);
        check_word("accepted beats after stall", row.exp_accept, accepted);
        check_beat("held beat after stall", make_beat(0), rd_beat);
        hold_rd = 1'b0;
    endtask

    // --------------------
    // Test table
    task automatic load_table();
        row_name[0]   = "stream_40";
        test_table[0] = '{n_beats: 40, base: 16'h1000, pkt_len: 5,
                          gaps: 1'b1, stalls: 1'b1, hold: 1'b0,
                          wr_thresh: 32'h0, rd_thresh: 32'h0,
                          exp_wr_thresh: 32'h0, exp_rd_thresh: 32'h0,
                          exp_accept: 32'h0, full_wr_level: 32'h0, full_rd_level: 32'h0,
                          full_af: 2'b00, full_ae: 2'b00,
                          drain_af: 2'b11, drain_ae: 2'b11};
        // Upper byte of a threshold write is dropped
        row_name[1]   = "thresh_wide";
        test_table[1] = '{n_beats: 4, base: 16'h2200, pkt_len: 2,
                          gaps: 1'b1, stalls: 1'b1, hold: 1'b0,
                          wr_thresh: 32'hff00_0013, rd_thresh: 32'h7f12_3456,
                          exp_wr_thresh: 32'h0000_0013, exp_rd_thresh: 32'h0012_3456,
                          exp_accept: 32'h0, full_wr_level: 32'h0, full_rd_level: 32'h0,
                          full_af: 2'b00, full_ae: 2'b00,
                          drain_af: 2'b10, drain_ae: 2'b11};
        // Memory plus output register when full
        row_name[2]   = "backpressure";
        test_table[2] = '{n_beats: 20, base: 16'h3a00, pkt_len: 4,
                          gaps: 1'b0, stalls: 1'b0, hold: 1'b1,
                          wr_thresh: 32'd10, rd_thresh: 32'd4,
                          exp_wr_thresh: 32'd10, exp_rd_thresh: 32'd4,
                          exp_accept: DEPTH + 1, full_wr_level: DEPTH,
                          full_rd_level: DEPTH + 1,
                          full_af: 2'b11, full_ae: 2'b10,
                          drain_af: 2'b10, drain_ae: 2'b11};
    endtask

    // --------------------
    // Main sequence
    initial begin
        csr_data_t rdata;
        void'($urandom(32'h1cc7));
        in_reset_n   = 1'b0;
        rd_reset_n   = 1'b0;
        wr_beat      = '0;
        wr_valid     = 1'b0;
        rd_ready     = 1'b0;
        wr_csr       = '0;
        rd_csr       = '0;
        accepted     = 0;
        stall_run    = 0;
        hold_rd      = 1'b0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_table();
        cycle_limit = 400;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += 60 * test_table[r].n_beats;
        end

        // Reset for 3 cycles of each clock
        start_test("reset");
        fork
            begin
                repeat (3) @(posedge in_clk);
                #0.5;
                in_reset_n = 1'b1;
            end
            begin
                repeat (3) @(posedge rd_clk);
                #0.5;
                rd_reset_n = 1'b1;
            end
            begin
                side_edge(1'b1);
                check_flag("almost_full in reset", 2'b00, almost_full);
                check_flag("almost_empty in reset", 2'b00, almost_empty);
                check_word("write read data in reset", '0, wr_csr_readdata);
                check_word("read read data in reset", '0, rd_csr_readdata);
            end
        join
        side_edge(1'b0);
        check_bit("wr_ready after reset", 1'b1, wr_ready);
        check_word("write read data after reset", '0, wr_csr_readdata);
        side_edge(1'b1);
        check_bit("rd_valid after reset", 1'b0, rd_valid);
        check_word("read read data after reset", '0, rd_csr_readdata);
        finish_test();

        for (int r = 0; r < NUM_ROWS; r++) begin
            row = test_table[r];
            start_test(row_name[r]);
            accepted  = 0;
            stall_run = 0;
            hold_rd   = row.hold;
            // Thresholds written and read back
            csr_access(1'b0, `DCF_CSR_THRESH, 1'b1, row.wr_thresh, rdata);
            csr_access(1'b0, `DCF_CSR_THRESH, 1'b0, '0, rdata);
            check_word("write threshold", row.exp_wr_thresh, rdata);
            csr_access(1'b1, `DCF_CSR_THRESH, 1'b1, row.rd_thresh, rdata);
            csr_access(1'b1, `DCF_CSR_THRESH, 1'b0, '0, rdata);
            check_word("read threshold", row.exp_rd_thresh, rdata);

            fork
                send_beats();
                receive_beats();
                begin
                    if (row.hold) begin
                        check_full_state();
                    end
                end
            join

            // Pointers cross and levels settle after the drain
            repeat (SETTLE + 10) side_edge(1'b0);
            check_bit("rd_valid after drain", 1'b0, rd_valid);
            csr_access(1'b0, `DCF_CSR_FILL, 1'b0, '0, rdata);
            check_word("write level after drain", '0, rdata);
            check_flag("almost_full after drain", row.drain_af, almost_full);
            csr_access(1'b1, `DCF_CSR_FILL, 1'b0, '0, rdata);
            check_word("read level after drain", '0, rdata);
            check_flag("almost_empty after drain", row.drain_ae, almost_empty);
            finish_test();
        end

        $display("Summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: dc_fifo.f
+incdir+common
common/dc_fifo_stream_pkg.sv
common/dc_fifo_ptr_pkg.sv
ptr_ctrl/gray_sync.sv
ptr_ctrl/wr_ptr_ctrl.sv
ptr_ctrl/rd_ptr_ctrl.sv
source/dc_fifo_mem.sv
source/dc_fifo_out_stage.sv
source/level_csr.sv
source/dc_fifo_top.sv
dv/tb_dc_fifo.sv

// File: Bender.yml
package:
  name: dc_fifo

sources:
  - include_dirs:
      - common
    files:
      - common/dc_fifo_stream_pkg.sv
      - common/dc_fifo_ptr_pkg.sv
      - ptr_ctrl/gray_sync.sv
      - ptr_ctrl/wr_ptr_ctrl.sv
      - ptr_ctrl/rd_ptr_ctrl.sv
      - source/dc_fifo_mem.sv
      - source/dc_fifo_out_stage.sv
      - source/level_csr.sv
      - source/dc_fifo_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_dc_fifo.sv
